// File: Bender.yml
package:
  name: cbus_xlat

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cbus_pkg.sv
      - common/cbus_if.sv
      - hdl/cbus_arbiter.sv
      - mmu/addr_translator.sv
      - mmu/xlat_regs.sv
      - hdl/cbus_xlat_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_cbus_xlat.sv

// File: build.f
+incdir+common
common/cbus_pkg.sv
common/cbus_if.sv
hdl/cbus_arbiter.sv
mmu/addr_translator.sv
mmu/xlat_regs.sv
hdl/cbus_xlat_top.sv
testbench/tb_mem_model.sv
testbench/tb_cbus_xlat.sv

// File: common/cbus_cfg.svh
`ifndef CBUS_CFG_SVH
`define CBUS_CFG_SVH

// Number of clients in front of the arbiter.
`define CBUS_NUM_CLIENTS 2

// Translation geometry.
`define CBUS_NUM_PAGES 8
`define CBUS_PAGE_BITS 12

// Config register map, in word addresses.
`define CBUS_REG_MODE     0
`define CBUS_REG_PTE_BASE 1

`endif

// File: common/cbus_if.sv
`default_nettype none

interface cbus_if;
    import cbus_pkg::*;

    logic   valid;
    logic   write;  // High for a store.
    vaddr_t addr;
    data_t  wdata;
    strb_t  strb;
    logic   ready;  // Single-cycle response strobe.
    data_t  rdata;
    logic   fault;

    modport requester (
        output valid,
        output write,
        output addr,
        output wdata,
        output strb,
        input  ready,
        input  rdata,
        input  fault
    );

    modport responder (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        input  strb,
        output ready,
        output rdata,
        output fault
    );

endinterface

`default_nettype wire

// File: common/cbus_pkg.sv
`default_nettype none

package cbus_pkg;

    typedef logic [31:0] vaddr_t;  // Virtual address as issued by a client.
    typedef logic [31:0] paddr_t;  // Physical address seen by memory.
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;   // One enable per byte lane.
    typedef logic [19:0] ppn_t;

    // Page entry, also the register image below bit 21 of the config word.
    typedef struct packed {
        logic valid;
        ppn_t ppn;
    } pte_t;

    // Encodings follow the usual RISC-V privilege numbering.
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [1:0] {
        XLAT_IDLE,
        XLAT_LOOKUP,
        XLAT_MEM_WAIT,
        XLAT_RESPOND
    } xlat_state_t;

endpackage

`default_nettype wire

// File: hdl/cbus_arbiter.sv
`default_nettype none

`include "cbus_cfg.svh"

module cbus_arbiter #(
    parameter int num_clients = `CBUS_NUM_CLIENTS
) (
    input  logic      clk,
    input  logic      rst_n,
    cbus_if.responder clients [num_clients],
    cbus_if.requester downstream
);
    import cbus_pkg::*;

    localparam int idx_w = (num_clients > 1) ? $clog2(num_clients) : 1;

    logic [num_clients-1:0] req_valid;
    logic [num_clients-1:0] req_write;
    vaddr_t                 req_addr  [num_clients];
    data_t                  req_wdata [num_clients];
    strb_t                  req_strb  [num_clients];

    logic             grant_vld;
    logic [idx_w-1:0] grant_idx;
    logic             pick_any;
    logic [idx_w-1:0] pick_idx;

    // Flatten the interface array so the grant index can select from it.
    for (genvar i = 0; i < num_clients; i++) begin : g_client
        logic sel;

        assign sel = grant_vld && (grant_idx == idx_w'(i));

        assign req_valid[i] = clients[i].valid;
        assign req_write[i] = clients[i].write;
        assign req_addr[i]  = clients[i].addr;
        assign req_wdata[i] = clients[i].wdata;
        assign req_strb[i]  = clients[i].strb;

        assign clients[i].ready = sel && downstream.ready;
        assign clients[i].rdata = sel ? downstream.rdata : '0;
        assign clients[i].fault = sel && downstream.fault;
    end

    // Lowest index wins.
    always_comb begin
        pick_any = 1'b0;
        pick_idx = '0;
        for (int i = num_clients - 1; i >= 0; i--) begin
            if (req_valid[i]) begin
                pick_any = 1'b1;
                pick_idx = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_vld <= 1'b0;
            grant_idx <= '0;
        end else if (!grant_vld) begin
            grant_vld <= pick_any;
            grant_idx <= pick_idx;
        end else if (downstream.ready) begin
            grant_vld <= 1'b0;  // Free again on the edge after the response.
        end
    end

    assign downstream.valid = grant_vld && req_valid[grant_idx];
    assign downstream.write = req_write[grant_idx];
    assign downstream.addr  = req_addr[grant_idx];
    assign downstream.wdata = req_wdata[grant_idx];
    assign downstream.strb  = req_strb[grant_idx];

    // The granted client must keep its request up until it is answered.
    a_hold_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        downstream.valid && !downstream.ready |=> downstream.valid
    );

endmodule

`default_nettype wire

// File: hdl/cbus_xlat_top.sv
`default_nettype none

`include "cbus_cfg.svh"

module cbus_xlat_top (
    input  logic             clk,
    input  logic             rst_n,
    input  cbus_pkg::priv_t  priv,
    input  logic             c0_valid,
    input  logic             c0_write,
    input  cbus_pkg::vaddr_t c0_addr,
    input  cbus_pkg::data_t  c0_wdata,
    input  cbus_pkg::strb_t  c0_strb,
    output logic             c0_ready,
    output cbus_pkg::data_t  c0_rdata,
    output logic             c0_fault,
    input  logic             c1_valid,
    input  logic             c1_write,
    input  cbus_pkg::vaddr_t c1_addr,
    input  cbus_pkg::data_t  c1_wdata,
    input  cbus_pkg::strb_t  c1_strb,
    output logic             c1_ready,
    output cbus_pkg::data_t  c1_rdata,
    output logic             c1_fault,
    output logic             mem_valid,
    output logic             mem_write,
    output cbus_pkg::paddr_t mem_addr,
    output cbus_pkg::data_t  mem_wdata,
    output cbus_pkg::strb_t  mem_strb,
    input  logic             mem_ready,
    input  cbus_pkg::data_t  mem_rdata,
    input  logic             cfg_cyc,
    input  logic             cfg_stb,
    input  logic             cfg_we,
    input  logic [3:0]       cfg_adr,
    input  cbus_pkg::data_t  cfg_dat_w,
    output cbus_pkg::data_t  cfg_dat_r,
    output logic             cfg_ack
);
    import cbus_pkg::*;

    pte_t pte_tab [`CBUS_NUM_PAGES];
    logic xlat_en;

    cbus_if client_bus [2] ();
    cbus_if link ();

    // Client 0 is the higher priority port.
    assign client_bus[0].valid = c0_valid;
    assign client_bus[0].write = c0_write;
    assign client_bus[0].addr  = c0_addr;
    assign client_bus[0].wdata = c0_wdata;
    assign client_bus[0].strb  = c0_strb;
    assign c0_ready            = client_bus[0].ready;
    assign c0_rdata            = client_bus[0].rdata;
    assign c0_fault            = client_bus[0].fault;

    assign client_bus[1].valid = c1_valid;
    assign client_bus[1].write = c1_write;
    assign client_bus[1].addr  = c1_addr;
    assign client_bus[1].wdata = c1_wdata;
    assign client_bus[1].strb  = c1_strb;
    assign c1_ready            = client_bus[1].ready;
    assign c1_rdata            = client_bus[1].rdata;
    assign c1_fault            = client_bus[1].fault;

    cbus_arbiter #(
        .num_clients (2)
    ) i_cbus_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .clients    (client_bus),
        .downstream (link)
    );

    addr_translator i_addr_translator (
        .clk       (clk),
        .rst_n     (rst_n),
        .upstream  (link),
        .priv      (priv),
        .xlat_en   (xlat_en),
        .pte       (pte_tab),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    xlat_regs i_xlat_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_cyc   (cfg_cyc),
        .cfg_stb   (cfg_stb),
        .cfg_we    (cfg_we),
        .cfg_adr   (cfg_adr),
        .cfg_dat_w (cfg_dat_w),
        .cfg_dat_r (cfg_dat_r),
        .cfg_ack   (cfg_ack),
        .xlat_en   (xlat_en),
        .pte       (pte_tab)
    );

endmodule

`default_nettype wire

// File: mmu/addr_translator.sv
`default_nettype none

`include "cbus_cfg.svh"

module addr_translator (
    input  logic             clk,
    input  logic             rst_n,
    cbus_if.responder        upstream,
    input  cbus_pkg::priv_t  priv,
    input  logic             xlat_en,
    input  cbus_pkg::pte_t   pte [`CBUS_NUM_PAGES],
    output logic             mem_valid,
    output logic             mem_write,
    output cbus_pkg::paddr_t mem_addr,
    output cbus_pkg::data_t  mem_wdata,
    output cbus_pkg::strb_t  mem_strb,
    input  logic             mem_ready,
    input  cbus_pkg::data_t  mem_rdata
);
    import cbus_pkg::*;

    localparam int pg_idx_w = $clog2(`CBUS_NUM_PAGES);
    localparam int vpn_w    = $bits(vaddr_t) - `CBUS_PAGE_BITS;

    xlat_state_t state;
    logic        req_write;
    vaddr_t      req_addr;
    data_t       req_wdata;
    strb_t       req_strb;
    paddr_t      phys_addr;
    data_t       rdata_q;
    logic        fault_q;

    logic [vpn_w-1:0] vpn;
    pte_t             entry;
    logic             bypass;
    logic             miss;
    paddr_t           mapped;

    always_comb begin
        vpn    = req_addr[$bits(vaddr_t)-1:`CBUS_PAGE_BITS];
        entry  = pte[vpn[pg_idx_w-1:0]];
        bypass = (priv == PRIV_M) || !xlat_en;
        miss   = (vpn >= `CBUS_NUM_PAGES) || !entry.valid;
        mapped = {entry.ppn, req_addr[`CBUS_PAGE_BITS-1:0]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= XLAT_IDLE;
            mem_valid <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            case (state)
                XLAT_IDLE: begin
                    if (upstream.valid) begin
                        state <= XLAT_LOOKUP;
                    end
                end
                XLAT_LOOKUP: begin
                    if (!bypass && miss) begin
                        fault_q <= 1'b1;  // Skip memory entirely.
                        state   <= XLAT_RESPOND;
                    end else begin
                        fault_q   <= 1'b0;
                        mem_valid <= 1'b1;
                        state     <= XLAT_MEM_WAIT;
                    end
                end
                XLAT_MEM_WAIT: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        state     <= XLAT_RESPOND;
                    end
                end
                default: state <= XLAT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == XLAT_IDLE && upstream.valid) begin
            req_write <= upstream.write;
            req_addr  <= upstream.addr;
            req_wdata <= upstream.wdata;
            req_strb  <= upstream.strb;
        end
        if (state == XLAT_LOOKUP) begin
            phys_addr <= bypass ? paddr_t'(req_addr) : mapped;
            if (!bypass && miss) begin
                rdata_q <= '0;
            end
        end
        if (state == XLAT_MEM_WAIT && mem_ready) begin
            rdata_q <= mem_rdata;
        end
    end

    assign upstream.ready = (state == XLAT_RESPOND);
    assign upstream.rdata = rdata_q;
    assign upstream.fault = fault_q;

    assign mem_write = req_write;
    assign mem_addr  = phys_addr;
    assign mem_wdata = req_wdata;
    assign mem_strb  = req_strb;

    // Memory must be quiet while the client is being answered.
    a_no_mem_in_respond: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == XLAT_RESPOND |-> !mem_valid
    );

endmodule

`default_nettype wire

// File: mmu/xlat_regs.sv
`default_nettype none

`include "cbus_cfg.svh"

module xlat_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_cyc,
    input  logic            cfg_stb,
    input  logic            cfg_we,
    input  logic [3:0]      cfg_adr,
    input  cbus_pkg::data_t cfg_dat_w,
    output cbus_pkg::data_t cfg_dat_r,
    output logic            cfg_ack,
    output logic            xlat_en,
    output cbus_pkg::pte_t  pte [`CBUS_NUM_PAGES]
);
    import cbus_pkg::*;

    logic access;
    logic wr_en;

    // One access per cycle of cyc and stb, ack blocks a repeat.
    assign access = cfg_cyc && cfg_stb && !cfg_ack;
    assign wr_en  = access && cfg_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack <= 1'b0;
            xlat_en <= 1'b0;
            for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
                pte[i] <= '0;
            end
        end else begin
            cfg_ack <= access;
            if (wr_en && cfg_adr == 4'(`CBUS_REG_MODE)) begin
                xlat_en <= cfg_dat_w[0];
            end
            for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
                if (wr_en && cfg_adr == 4'(`CBUS_REG_PTE_BASE + i)) begin
                    pte[i] <= pte_t'(cfg_dat_w[$bits(pte_t)-1:0]);  // Bit 20 valid.
                end
            end
        end
    end

    // Unmapped addresses fall through as zero.
    always_comb begin
        cfg_dat_r = '0;
        if (cfg_adr == 4'(`CBUS_REG_MODE)) begin
            cfg_dat_r = data_t'(xlat_en);
        end
        for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
            if (cfg_adr == 4'(`CBUS_REG_PTE_BASE + i)) begin
                cfg_dat_r = data_t'(pte[i]);
            end
        end
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_ack && cfg_stb |=> !cfg_ack
    );

endmodule

`default_nettype wire

// File: testbench/tb_cbus_xlat.sv
`default_nettype none

`include "cbus_cfg.svh"

module tb_cbus_xlat;
    timeunit 1ns;
    timeprecision 1ps;
    import cbus_pkg::*;

    logic   clk;
    logic   rst_n;
    priv_t  priv;
    logic   c0_valid, c0_write, c0_ready, c0_fault;
    vaddr_t c0_addr;
    data_t  c0_wdata, c0_rdata;
    strb_t  c0_strb;
    logic   c1_valid, c1_write, c1_ready, c1_fault;
    vaddr_t c1_addr;
    data_t  c1_wdata, c1_rdata;
    strb_t  c1_strb;
    logic   mem_valid, mem_write, mem_ready;
    paddr_t mem_addr;
    data_t  mem_wdata, mem_rdata;
    strb_t  mem_strb;
    logic   cfg_cyc, cfg_stb, cfg_we, cfg_ack;
    logic [3:0] cfg_adr;
    data_t  cfg_dat_w, cfg_dat_r;

    int unsigned mem_cnt;
    paddr_t      mem_last_addr;
    logic        mem_last_write;
    strb_t       mem_last_strb;

    // Shadow copies of the register state and of memory.
    logic        sh_xlat_en;
    pte_t        sh_pte [`CBUS_NUM_PAGES];
    priv_t       sh_priv;
    data_t       sh_mem [logic [29:0]];

    int          errors = 0;
    int          test_num = 0;
    int          tests_failed = 0;
    int          err_base = 0;
    int unsigned c0_ready_cnt = 0;
    int unsigned c1_ready_cnt = 0;

    cbus_xlat_top i_cbus_xlat_top (.*);

    tb_mem_model i_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_strb   (mem_strb),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .access_cnt (mem_cnt),
        .last_addr  (mem_last_addr),
        .last_write (mem_last_write),
        .last_strb  (mem_last_strb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (c0_ready) c0_ready_cnt <= c0_ready_cnt + 1;
        if (c1_ready) c1_ready_cnt <= c1_ready_cnt + 1;
    end

    // Predicts the physical address and returns 1 for a fault.
    function automatic logic expected_access(input vaddr_t va, output paddr_t pa);
        logic [19:0] vpn;
        vpn = va[31:`CBUS_PAGE_BITS];
        pa  = va;
        if (sh_priv == PRIV_M || !sh_xlat_en) return 1'b0;
        if (vpn >= `CBUS_NUM_PAGES || !sh_pte[vpn[2:0]].valid) return 1'b1;
        pa = {sh_pte[vpn[2:0]].ppn, va[11:0]};
        return 1'b0;
    endfunction

    function automatic data_t pattern(input vaddr_t va);
        return va ^ 32'h3c5a_9600 ^ (test_num << 24);
    endfunction

    // Stores write the whole word, loads carry a mask taken from the address.
    function automatic strb_t lane_enables(input logic wr, input vaddr_t va);
        return wr ? 4'hf : va[5:2];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        test_num++;
        err_base = errors;
    endtask

    task automatic report_test(input string name);
        if (errors != err_base) tests_failed++;
        $display("test %0d %s: %s", test_num, name, (errors == err_base) ? "ok" : "failed");
    endtask

    task automatic cfg_access(input logic we, input logic [3:0] adr, input data_t dat,
                              output data_t rd);
        int   n;
        logic ack;
        @(posedge clk);
        cfg_cyc   <= 1'b1;
        cfg_stb   <= 1'b1;
        cfg_we    <= we;
        cfg_adr   <= adr;
        cfg_dat_w <= dat;
        n   = 0;
        ack = 1'b0;
        rd  = '0;
        while (!ack && n < 50) begin
            @(posedge clk);
            n++;
            ack = cfg_ack;
            rd  = cfg_dat_r;
        end
        if (!ack) begin
            $display("timeout waiting for config acknowledge at address %0d", adr);
            errors++;
        end
        cfg_cyc <= 1'b0;
        cfg_stb <= 1'b0;
        cfg_we  <= 1'b0;
    endtask

    task automatic client_access(input int c, input logic wr, input vaddr_t va,
                                 input data_t wd, output data_t rd, output logic flt,
                                 output time t_done);
        int   n;
        logic rdy;
        @(posedge clk);
        if (c == 0) begin
            c0_valid <= 1'b1;
            c0_write <= wr;
            c0_addr  <= va;
            c0_wdata <= wd;
            c0_strb  <= lane_enables(wr, va);
        end else begin
            c1_valid <= 1'b1;
            c1_write <= wr;
            c1_addr  <= va;
            c1_wdata <= wd;
            c1_strb  <= lane_enables(wr, va);
        end
        n      = 0;
        rdy    = 1'b0;
        rd     = '0;
        flt    = 1'b0;
        t_done = 0;
        while (!rdy && n < 200) begin
            @(posedge clk);
            n++;
            rdy    = (c == 0) ? c0_ready : c1_ready;
            rd     = (c == 0) ? c0_rdata : c1_rdata;
            flt    = (c == 0) ? c0_fault : c1_fault;
            t_done = $time;
        end
        if (!rdy) begin
            $display("timeout waiting for client %0d ready", c);
            errors++;
        end
        if (c == 0) c0_valid <= 1'b0;
        else c1_valid <= 1'b0;
    endtask

    task automatic run_access(input int c, input logic wr, input vaddr_t va);
        paddr_t      pa;
        logic        exp_fault;
        int unsigned cnt0;
        data_t       rd;
        data_t       wd;
        logic        flt;
        time         t;
        exp_fault = expected_access(va, pa);
        cnt0      = mem_cnt;
        wd        = pattern(va);
        client_access(c, wr, va, wd, rd, flt, t);
        check("fault", flt, exp_fault);
        if (exp_fault) begin
            check("memory access count", mem_cnt, cnt0);  // No access for a fault.
        end else begin
            check("memory access count", mem_cnt, cnt0 + 1);
            check("mem_addr", mem_last_addr, pa);
            check("mem_write", mem_last_write, wr);
            check("mem_strb", mem_last_strb, lane_enables(wr, va));
            if (wr) sh_mem[pa[31:2]] = wd;
            else check("rdata", rd, sh_mem[pa[31:2]]);
        end
    endtask

    task automatic store_then_load(input int c, input vaddr_t va [4]);
        for (int i = 0; i < 4; i++) run_access(c, 1'b1, va[i]);
        for (int i = 0; i < 4; i++) run_access(c, 1'b0, va[i]);
    endtask

    initial begin
        vaddr_t      addrs [4];
        data_t       rd, rd0, rd1;
        logic        f0, f1;
        time         t0, t1;
        int unsigned r0, r1;
        paddr_t      pa0, pa1;
        rst_n = 1'b0;
        priv = PRIV_U;
        sh_priv = PRIV_U;
        sh_xlat_en = 1'b0;
        {c0_valid, c0_write, c0_addr, c0_wdata, c0_strb} = '0;
        {c1_valid, c1_write, c1_addr, c1_wdata, c1_strb} = '0;
        {cfg_cyc, cfg_stb, cfg_we, cfg_adr, cfg_dat_w} = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        check("mem_valid", mem_valid, 1'b0);
        check("c0_ready", c0_ready, 1'b0);
        check("c1_ready", c1_ready, 1'b0);
        check("cfg_ack", cfg_ack, 1'b0);
        cfg_access(1'b0, `CBUS_REG_MODE, '0, rd);
        check("cfg_dat_r", rd, 32'h0);
        for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
            cfg_access(1'b0, 4'(`CBUS_REG_PTE_BASE + i), '0, rd);
            check("cfg_dat_r", rd, 32'h0);  // Entries come out of reset invalid.
        end
        cfg_access(1'b1, `CBUS_REG_MODE, 32'h1, rd);
        cfg_access(1'b0, `CBUS_REG_MODE, '0, rd);
        check("cfg_dat_r", rd, 32'h1);
        cfg_access(1'b1, `CBUS_REG_MODE, 32'h0, rd);
        for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
            sh_pte[i].valid = (i != 3 && i != 6);
            sh_pte[i].ppn   = 20'h40 + 20'h11 * i;
            cfg_access(1'b1, 4'(`CBUS_REG_PTE_BASE + i), data_t'(sh_pte[i]), rd);
        end
        cfg_access(1'b1, 4'hc, 32'hffff_ffff, rd);
        cfg_access(1'b0, `CBUS_REG_MODE, '0, rd);
        check("cfg_dat_r", rd, 32'h0);
        for (int i = 0; i < `CBUS_NUM_PAGES; i++) begin
            cfg_access(1'b0, 4'(`CBUS_REG_PTE_BASE + i), '0, rd);
            check("cfg_dat_r", rd, data_t'(sh_pte[i]));
        end
        cfg_access(1'b0, 4'hc, '0, rd);
        check("cfg_dat_r", rd, 32'h0);
        report_test("config registers");

        start_test();
        addrs = '{32'h0000_0100, 32'h0000_0104, 32'h0000_2008, 32'h0001_fffc};
        store_then_load(0, addrs);
        report_test("translation off");

        start_test();
        cfg_access(1'b1, `CBUS_REG_MODE, 32'h1, rd);
        sh_xlat_en = 1'b1;
        addrs = '{32'h0000_0010, 32'h0000_1234, 32'h0000_2ff8, 32'h0000_7abc};
        store_then_load(0, addrs);
        report_test("user translation");

        start_test();
        addrs = '{32'h0000_3000, 32'h0000_6ffc, 32'h0000_8000, 32'h1234_5000};
        store_then_load(0, addrs);
        report_test("translation faults");

        start_test();
        run_access(0, 1'b1, 32'h0000_0040);
        run_access(0, 1'b1, 32'h0000_1040);
        void'(expected_access(32'h0000_0040, pa0));
        void'(expected_access(32'h0000_1040, pa1));
        @(posedge clk);
        r0 = c0_ready_cnt;
        r1 = c1_ready_cnt;
        fork
            client_access(0, 1'b0, 32'h0000_0040, '0, rd0, f0, t0);
            client_access(1, 1'b0, 32'h0000_1040, '0, rd1, f1, t1);
        join
        @(posedge clk);
        check("c0_rdata", rd0, sh_mem[pa0[31:2]]);
        check("c1_rdata", rd1, sh_mem[pa1[31:2]]);
        check("c0_fault", f0, 1'b0);
        check("c1_fault", f1, 1'b0);
        check("c0 ready before c1 ready", t0 < t1, 1'b1);
        check("c0_ready pulses", c0_ready_cnt - r0, 1);
        check("c1_ready pulses", c1_ready_cnt - r1, 1);
        report_test("two clients");

        start_test();
        @(posedge clk);
        priv <= PRIV_M;
        sh_priv = PRIV_M;
        addrs = '{32'h0000_3000, 32'h0000_6ffc, 32'h0000_9000, 32'hdead_beec};
        store_then_load(0, addrs);
        report_test("machine pass-through");

        $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`default_nettype none

module tb_mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_valid,
    input  logic              mem_write,
    input  cbus_pkg::paddr_t  mem_addr,
    input  cbus_pkg::data_t   mem_wdata,
    input  cbus_pkg::strb_t   mem_strb,
    output logic              mem_ready,
    output cbus_pkg::data_t   mem_rdata,
    output int unsigned       access_cnt,
    output cbus_pkg::paddr_t  last_addr,
    output logic              last_write,
    output cbus_pkg::strb_t   last_strb
);
    timeunit 1ns;
    timeprecision 1ps;
    import cbus_pkg::*;

    data_t       mem [logic [29:0]];  // Sparse word store.
    logic        busy;
    logic [31:0] rng;
    int unsigned delay;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unwritten words read back a pattern of their own address.
    function automatic data_t read_word(input paddr_t a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'ha5c3_0f96;
    endfunction

    always @(posedge clk or negedge rst_n) begin : serve
        data_t word;
        if (!rst_n) begin
            mem_ready  <= 1'b0;
            mem_rdata  <= '0;
            busy       <= 1'b0;
            delay      <= 0;
            rng        <= 32'd85;
            access_cnt <= 0;
            last_addr  <= '0;
            last_write <= 1'b0;
            last_strb  <= '0;
        end else begin
            mem_ready <= 1'b0;
            if (mem_valid && !busy && !mem_ready) begin
                busy  <= 1'b1;
                rng   <= xorshift32(rng);
                delay <= xorshift32(rng) % 5;  // 0 to 4 extra cycles.
            end else if (busy) begin
                if (delay == 0) begin
                    word = read_word(mem_addr);
                    if (mem_write) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_strb[b]) begin
                                word[8*b +: 8] = mem_wdata[8*b +: 8];
                            end
                        end
                        mem[mem_addr[31:2]] = word;
                    end
                    mem_rdata  <= word;
                    mem_ready  <= 1'b1;
                    busy       <= 1'b0;
                    access_cnt <= access_cnt + 1;
                    last_addr  <= mem_addr;
                    last_write <= mem_write;
                    last_strb  <= mem_strb;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire
